/* src.f */
lsu_pkg.sv
lsu_store_align.sv
lsu_load_extract.sv
lsu_bus_ctrl.sv
lsu_top.sv
tb_lsu_assert.sv
tb_lsu.sv

/* tb_lsu.sv */
// Load/store unit testbench
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

   logic                clk;
   logic                rst_n;
   lsu_pkg::lsu_cmd_t   cmd;
   logic                cmd_valid;
   logic                cmd_ready;
   lsu_pkg::ahb_req_t   ahb_req;
   logic [31:0]         hwdata;
   logic [3:0]          hstrb;
   logic [31:0]         hrdata;
   logic                hready;
   lsu_pkg::lsu_wb_t    wb;
   logic                wb_valid;

   // Stimulus table and expected load results
   lsu_pkg::lsu_cmd_t   tab_cmd[$];
   string               tab_name[$];
   logic [31:0]         tab_exp[$];
   string               exp_name_q[$];
   logic [4:0]          exp_rd_q[$];
   logic [31:0]         exp_data_q[$];

   logic [31:0]         mem[0:63];
   logic [31:0]         shadow[0:63];
   logic                dp_active;
   logic                dp_write;
   logic [5:0]          dp_index;
   int unsigned         wait_left;
   int                  errors;
   int                  loads_expected;
   int                  loads_seen;
   int                  cycles;
   int                  cycle_limit;

   lsu_top uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .ahb_req   (ahb_req),
      .hwdata    (hwdata),
      .hstrb     (hstrb),
      .hrdata    (hrdata),
      .hready    (hready),
      .wb        (wb),
      .wb_valid  (wb_valid)
   );

   always #20 clk = ~clk;

   // ====================
   // Reference model
   // ====================
   function automatic logic [31:0] fill_word(int i);
      return (32'h9e37_79b9 * (i + 1)) ^ (i << 24);
   endfunction

   function automatic logic [31:0] load_value(logic [31:0] word, lsu_pkg::mem_size_e sz,
                                              logic [1:0] off, logic uns);
      logic [31:0] value;
      if (sz == lsu_pkg::size_byte) begin
         value = (word >> (8 * off)) & 32'h0000_00ff;
         if (!uns && value[7])
            value = value | 32'hffff_ff00;
      end else if (sz == lsu_pkg::size_half) begin
         value = (word >> (16 * off[1])) & 32'h0000_ffff;
         if (!uns && value[15])
            value = value | 32'hffff_0000;
      end else begin
         value = word;
      end
      return value;
   endfunction

   // AHB hsize code for each access size
   function automatic logic [2:0] hsize_code(lsu_pkg::mem_size_e sz);
      case (sz)
         lsu_pkg::size_byte: return 3'd0;
         lsu_pkg::size_half: return 3'd1;
         default:            return 3'd2;
      endcase
   endfunction

   // Byte enables a store must raise
   function automatic logic [3:0] store_strobes(lsu_pkg::mem_size_e sz, logic [1:0] off);
      logic [3:0] strb;
      if (sz == lsu_pkg::size_byte)
         strb = 4'b0001 << off;
      else if (sz == lsu_pkg::size_half)
         strb = off[1] ? 4'b1100 : 4'b0011;
      else
         strb = 4'b1111;
      return strb;
   endfunction

   task automatic store_shadow(logic [31:0] addr, lsu_pkg::mem_size_e sz, logic [31:0] data);
      int idx;
      idx = addr[7:2];
      for (int k = 0; k < 4; k++) begin
         if (sz == lsu_pkg::size_byte) begin
            if (k == addr[1:0])
               shadow[idx][8*k +: 8] = data[7:0];
         end else if (sz == lsu_pkg::size_half) begin
            if (k / 2 == addr[1])
               shadow[idx][8*k +: 8] = data[8*(k%2) +: 8];
         end else begin
            shadow[idx][8*k +: 8] = data[8*k +: 8];
         end
      end
   endtask

   // Enables of a store during its data phase
   task automatic check_store_strobes(int i);
      if (tab_cmd[i].write &&
          hstrb !== store_strobes(tab_cmd[i].size, tab_cmd[i].addr[1:0])) begin
         $display("CHECK FAILED %s: expected hstrb %b, actual hstrb %b", tab_name[i],
                  store_strobes(tab_cmd[i].size, tab_cmd[i].addr[1:0]), hstrb);
         errors++;
      end
   endtask

   task automatic add_entry(string name, logic wr, lsu_pkg::mem_size_e sz, logic uns,
                            logic [31:0] addr, logic [31:0] wdata, logic [4:0] rs2,
                            logic [4:0] rd);
      lsu_pkg::lsu_cmd_t c;
      c = '{write: wr, size: sz, uns: uns, addr: addr, wdata: wdata, rs2: rs2, rd: rd};
      tab_cmd.push_back(c);
      tab_name.push_back(name);
   endtask

   task automatic build_table();
      add_entry("sw_word", 1, lsu_pkg::size_word, 0, 32'h10, 32'h1234_5678, 3, 0);
      add_entry("lw_word", 0, lsu_pkg::size_word, 0, 32'h10, 0, 0, 5);
      for (int k = 0; k < 4; k++)
         add_entry($sformatf("sb_off%0d", k), 1, lsu_pkg::size_byte, 0, 32'h20 + k,
                   32'h5555_55a1 + k * 32'h11, 4, 0);
      add_entry("lw_bytes", 0, lsu_pkg::size_word, 0, 32'h20, 0, 0, 6);
      add_entry("sh_off0", 1, lsu_pkg::size_half, 0, 32'h24, 32'h0000_beef, 4, 0);
      add_entry("sh_off2", 1, lsu_pkg::size_half, 0, 32'h26, 32'hffff_1234, 4, 0);
      add_entry("lw_halves", 0, lsu_pkg::size_word, 0, 32'h24, 0, 0, 7);
      add_entry("sw_signed", 1, lsu_pkg::size_word, 0, 32'h30, 32'hf17f_8035, 3, 0);
      for (int k = 0; k < 4; k++) begin
         add_entry($sformatf("lb_off%0d", k), 0, lsu_pkg::size_byte, 0, 32'h30 + k, 0, 0, 8);
         add_entry($sformatf("lbu_off%0d", k), 0, lsu_pkg::size_byte, 1, 32'h30 + k, 0, 0, 8);
      end
      for (int k = 0; k < 4; k += 2) begin
         add_entry($sformatf("lh_off%0d", k), 0, lsu_pkg::size_half, 0, 32'h30 + k, 0, 0, 8);
         add_entry($sformatf("lhu_off%0d", k), 0, lsu_pkg::size_half, 1, 32'h30 + k, 0, 0, 8);
      end
      add_entry("lw_src", 0, lsu_pkg::size_word, 0, 32'h10, 0, 0, 9);
      add_entry("sw_bypass", 1, lsu_pkg::size_word, 0, 32'h40, 32'hdead_beef, 9, 0);
      add_entry("lw_bypass", 0, lsu_pkg::size_word, 0, 32'h40, 0, 0, 10);
      add_entry("lw_fill", 0, lsu_pkg::size_word, 0, 32'h84, 0, 0, 11);
   endtask

   // Walk the table in order, a store right after a load takes the loaded value
   task automatic compute_expected();
      lsu_pkg::lsu_cmd_t c;
      logic              prev_load;
      logic [4:0]        prev_rd;
      logic [31:0]       prev_val;
      logic [31:0]       sdata;
      prev_load = 1'b0;
      prev_rd   = '0;
      prev_val  = '0;
      foreach (tab_cmd[i]) begin
         c = tab_cmd[i];
         if (c.write) begin
            sdata = (prev_load && c.rs2 == prev_rd) ? prev_val : c.wdata;
            store_shadow(c.addr, c.size, sdata);
            tab_exp.push_back(32'h0);
         end else begin
            prev_val = load_value(shadow[c.addr[7:2]], c.size, c.addr[1:0], c.uns);
            prev_rd  = c.rd;
            tab_exp.push_back(prev_val);
         end
         prev_load = !c.write;
      end
   endtask

   // ====================
   // Memory model
   // ====================
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_active <= 1'b0;
         dp_write  <= 1'b0;
         dp_index  <= '0;
         wait_left <= 0;
      end else if (hready) begin
         // Data phase ends here, commit enabled lanes
         if (dp_active && dp_write) begin
            for (int k = 0; k < 4; k++)
               if (hstrb[k])
                  mem[dp_index][8*k +: 8] <= hwdata[8*k +: 8];
         end
         dp_active <= (ahb_req.htrans == lsu_pkg::htrans_nonseq);
         dp_write  <= ahb_req.hwrite;
         dp_index  <= ahb_req.haddr[7:2];
         wait_left <= $urandom_range(2, 0);
      end else if (wait_left != 0) begin
         wait_left <= wait_left - 1;
      end
   end

   always @(negedge clk) begin
      hready <= !(dp_active && wait_left != 0);
      hrdata <= (dp_active && !dp_write) ? mem[dp_index] : 32'h0;
   end

   // Load results against the expected order
   always @(posedge clk) begin
      if (rst_n && wb_valid) begin
         if (exp_name_q.size() == 0) begin
            $display("Load result for x%0d arrived with no load outstanding", wb.rd);
            errors++;
         end else begin
            if (wb.rd != exp_rd_q[0]) begin
               $display("CHECK FAILED %s: expected rd %0d, actual rd %0d",
                        exp_name_q[0], exp_rd_q[0], wb.rd);
               errors++;
            end
            if (wb.data != exp_data_q[0]) begin
               $display("CHECK FAILED %s: expected data %h, actual data %h",
                        exp_name_q[0], exp_data_q[0], wb.data);
               errors++;
            end
            void'(exp_name_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            loads_seen++;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ====================
   // Main sequence
   // ====================
   initial begin
      void'($urandom(32'ha5cf_d779));
      clk            = 1'b0;
      rst_n          = 1'b0;
      cmd            = '0;
      cmd_valid      = 1'b0;
      hrdata         = '0;
      hready         = 1'b1;
      errors         = 0;
      loads_expected = 0;
      loads_seen     = 0;
      cycles         = 0;
      for (int i = 0; i < 64; i++) begin
         mem[i]    = fill_word(i);
         shadow[i] = fill_word(i);
      end
      build_table();
      compute_expected();
      cycle_limit = 4 * tab_cmd.size() * 3;

      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // Bus stays idle with no command pending
      repeat (2) begin
         @(posedge clk);
         if (ahb_req.htrans != lsu_pkg::htrans_idle) begin
            $display("CHECK FAILED reset_idle: expected htrans %0d, actual htrans %0d",
                     lsu_pkg::htrans_idle, ahb_req.htrans);
            errors++;
         end
         if (wb_valid !== 1'b0) begin
            $display("CHECK FAILED reset_idle: expected wb_valid 0, actual wb_valid %b",
                     wb_valid);
            errors++;
         end
      end

      foreach (tab_cmd[i]) begin
         @(negedge clk);
         // Previous command is now in its data phase
         if (i > 0)
            check_store_strobes(i - 1);
         cmd       = tab_cmd[i];
         cmd_valid = 1'b1;
         if (!tab_cmd[i].write) begin
            exp_name_q.push_back(tab_name[i]);
            exp_rd_q.push_back(tab_cmd[i].rd);
            exp_data_q.push_back(tab_exp[i]);
            loads_expected++;
         end
         @(posedge clk);
         while (!cmd_ready)
            @(posedge clk);
         if (ahb_req.hsize !== hsize_code(tab_cmd[i].size)) begin
            $display("CHECK FAILED %s: expected hsize %0d, actual hsize %0d",
                     tab_name[i], hsize_code(tab_cmd[i].size), ahb_req.hsize);
            errors++;
         end
      end
      @(negedge clk);
      check_store_strobes(tab_cmd.size() - 1);
      cmd_valid = 1'b0;

      while (exp_name_q.size() != 0)
         @(posedge clk);
      repeat (3) @(posedge clk);
      if (loads_seen != loads_expected) begin
         $display("Received %0d load results instead of %0d", loads_seen, loads_expected);
         errors++;
      end

      $display("Errors: %0d, load results checked: %0d", errors, loads_seen);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb_lsu_assert.sv */
// Data bus protocol assertions
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_assert (
   input logic        clk,
   input logic        rst_n,
   input logic [1:0]  htrans,
   input logic        hwrite,
   input logic        hready,
   input logic [31:0] hwdata,
   input logic [3:0]  hstrb,
   input logic        wb_valid
);

   // Results only on the cycle that ends the data phase of a load
   a_wb_ready: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> hready && ($past(!hready) ||
                              $past(htrans == lsu_pkg::htrans_nonseq && !hwrite)))
      else $error("wb_valid outside the end of a load data phase");

   // Wait states freeze the write data and enables
   a_wdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !hready |=> ($stable(hwdata) && $stable(hstrb)))
      else $error("hwdata or hstrb changed during a wait state");

   a_idle_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> htrans == lsu_pkg::htrans_idle)
      else $error("htrans not idle in the first cycle after reset");

endmodule

bind lsu_top tb_lsu_assert u_assert (
   .clk      (clk),
   .rst_n    (rst_n),
   .htrans   (ahb_req.htrans),
   .hwrite   (ahb_req.hwrite),
   .hready   (hready),
   .hwdata   (hwdata),
   .hstrb    (hstrb),
   .wb_valid (wb_valid)
);

`default_nettype wire

/* lsu_top.sv */
// Load/store unit top level
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
   input  logic                        clk,
   input  logic                        rst_n,
   input  lsu_pkg::lsu_cmd_t           cmd,
   input  logic                        cmd_valid,
   output logic                        cmd_ready,
   output lsu_pkg::ahb_req_t           ahb_req,
   output logic [lsu_pkg::xlen-1:0]    hwdata,
   output logic [3:0]                  hstrb,
   input  logic [lsu_pkg::xlen-1:0]    hrdata,
   input  logic                        hready,
   output lsu_pkg::lsu_wb_t            wb,
   output logic                        wb_valid
);

   logic [lsu_pkg::xlen-1:0] load_data;
   logic [lsu_pkg::xlen-1:0] store_data;
   logic [lsu_pkg::xlen-1:0] lane_data;
   logic [3:0]               lane_strb;
   logic [2:0]               hsize;
   lsu_pkg::lsu_pend_t       pend;

   // A new command is taken only when the previous data phase ends
   assign cmd_ready = hready;

   // ====================
   // Address phase
   // ====================
   assign ahb_req.haddr  = cmd.addr;
   assign ahb_req.htrans = cmd_valid ? lsu_pkg::htrans_nonseq : lsu_pkg::htrans_idle;
   assign ahb_req.hwrite = cmd.write;
   assign ahb_req.hsize  = hsize;

   // Result register index travels with the pending record
   assign wb.rd   = pend.rd;
   assign wb.data = load_data;

   // ====================
   // Datapath
   // ====================
   lsu_bus_ctrl u_bus_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .hready     (hready),
      .load_data  (load_data),
      .lane_data  (lane_data),
      .lane_strb  (lane_strb),
      .store_data (store_data),
      .pend       (pend),
      .hwdata     (hwdata),
      .hstrb      (hstrb),
      .wb_valid   (wb_valid)
   );

   lsu_store_align u_store_align (
      .size       (cmd.size),
      .byte_off   (cmd.addr[1:0]),
      .store_data (store_data),
      .lane_data  (lane_data),
      .lane_strb  (lane_strb),
      .hsize      (hsize)
   );

   lsu_load_extract u_load_extract (
      .pend       (pend),
      .hrdata     (hrdata),
      .load_data  (load_data)
   );

endmodule

`default_nettype wire

/* lsu_bus_ctrl.sv */
// Data bus phase control
`timescale 1ns/100ps
`default_nettype none

module lsu_bus_ctrl (
   input  logic                        clk,
   input  logic                        rst_n,
   input  lsu_pkg::lsu_cmd_t           cmd,
   input  logic                        cmd_valid,
   input  logic                        hready,
   input  logic [lsu_pkg::xlen-1:0]    load_data,
   input  logic [lsu_pkg::xlen-1:0]    lane_data,
   input  logic [3:0]                  lane_strb,
   output logic [lsu_pkg::xlen-1:0]    store_data,
   output lsu_pkg::lsu_pend_t          pend,
   output logic [lsu_pkg::xlen-1:0]    hwdata,
   output logic [3:0]                  hstrb,
   output logic                        wb_valid
);

   logic accept;
   logic load_done;
   logic bypass;

   // ====================
   // Handshake
   // ====================

   // Address phase taken when the bus is ready
   assign accept = cmd_valid & hready;

   // Pending load finishes its data phase this cycle
   assign load_done = pend.load & hready;

   assign wb_valid = load_done;

   // ====================
   // Load to store bypass
   // ====================

   // Store reads a register that the finishing load is about to write
   assign bypass = cmd.write & load_done & (cmd.rs2 == pend.rd);

   assign store_data = bypass ? load_data : cmd.wdata;

   // ====================
   // Data phase state
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend <= '0;
      end else if (accept) begin
         pend.load     <= ~cmd.write;
         pend.size     <= cmd.size;
         pend.uns      <= cmd.uns;
         pend.byte_off <= cmd.addr[1:0];
         pend.rd       <= cmd.rd;
      end else if (hready) begin
         // Bus went idle, nothing left in flight
         pend.load <= 1'b0;
      end
   end

   // Write data for the next data phase, strobes only for stores
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwdata <= '0;
         hstrb  <= 4'b0000;
      end else if (accept) begin
         hwdata <= lane_data;
         hstrb  <= cmd.write ? lane_strb : 4'b0000;
      end
   end

endmodule

`default_nettype wire

/* lsu_load_extract.sv */
// Load data extraction
`timescale 1ns/100ps
`default_nettype none

module lsu_load_extract (
   input  lsu_pkg::lsu_pend_t          pend,
   input  logic [lsu_pkg::xlen-1:0]    hrdata,
   output logic [lsu_pkg::xlen-1:0]    load_data
);

   logic [7:0]  sel_byte;
   logic [15:0] sel_half;

   // ====================
   // Lane selection
   // ====================
   always_comb begin
      case (pend.byte_off)
         2'b00:   sel_byte = hrdata[7:0];
         2'b01:   sel_byte = hrdata[15:8];
         2'b10:   sel_byte = hrdata[23:16];
         default: sel_byte = hrdata[31:24];
      endcase
   end

   // Halfword alignment taken from offset bit 1 only
   assign sel_half = pend.byte_off[1] ? hrdata[31:16] : hrdata[15:0];

   // ====================
   // Extension
   // ====================
   always_comb begin
      case (pend.size)
         lsu_pkg::size_byte: begin
            if (pend.uns) begin
               load_data = {24'b0, sel_byte};
            end else begin
               load_data = {{24{sel_byte[7]}}, sel_byte};
            end
         end
         lsu_pkg::size_half: begin
            if (pend.uns) begin
               load_data = {16'b0, sel_half};
            end else begin
               load_data = {{16{sel_half[15]}}, sel_half};
            end
         end
         default: begin
            // Full word, nothing to extend
            load_data = hrdata;
         end
      endcase
   end

endmodule

`default_nettype wire

/* lsu_store_align.sv */
// Store byte lane placement
`timescale 1ns/100ps
`default_nettype none

module lsu_store_align (
   input  lsu_pkg::mem_size_e          size,
   input  logic [1:0]                  byte_off,
   input  logic [lsu_pkg::xlen-1:0]    store_data,
   output logic [lsu_pkg::xlen-1:0]    lane_data,
   output logic [3:0]                  lane_strb,
   output logic [2:0]                  hsize
);

   // hsize is the size code widened to the bus field
   assign hsize = {1'b0, size};

   always_comb begin
      lane_data = '0;
      lane_strb = 4'b0000;
      case (size)
         lsu_pkg::size_byte: begin
            // Low byte goes to the lane picked by the offset
            case (byte_off)
               2'b00: begin
                  lane_data[7:0] = store_data[7:0];
                  lane_strb      = 4'b0001;
               end
               2'b01: begin
                  lane_data[15:8] = store_data[7:0];
                  lane_strb       = 4'b0010;
               end
               2'b10: begin
                  lane_data[23:16] = store_data[7:0];
                  lane_strb        = 4'b0100;
               end
               default: begin
                  lane_data[31:24] = store_data[7:0];
                  lane_strb        = 4'b1000;
               end
            endcase
         end
         lsu_pkg::size_half: begin
            // Offset bit 0 ignored, halfword stays aligned
            if (byte_off[1]) begin
               lane_data[31:16] = store_data[15:0];
               lane_strb        = 4'b1100;
            end else begin
               lane_data[15:0] = store_data[15:0];
               lane_strb       = 4'b0011;
            end
         end
         default: begin
            lane_data = store_data;
            lane_strb = 4'b1111;
         end
      endcase
   end

endmodule

`default_nettype wire

/* lsu_pkg.sv */
// Load/store unit types
`default_nettype none

package lsu_pkg;

   // ====================
   // Widths
   // ====================
   localparam int xlen      = 32;
   localparam int reg_idx_w = 5;

   // Transfer size, same encoding as the AHB hsize field
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } mem_size_e;

   // AHB transfer types in use
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   // ====================
   // Records
   // ====================

   // One memory command from the core side
   typedef struct packed {
      logic                 write;
      mem_size_e            size;
      logic                 uns;
      logic [xlen-1:0]      addr;
      logic [xlen-1:0]      wdata;
      logic [reg_idx_w-1:0] rs2;
      logic [reg_idx_w-1:0] rd;
   } lsu_cmd_t;

   // Access held over into the data phase
   typedef struct packed {
      logic                 load;
      mem_size_e            size;
      logic                 uns;
      logic [1:0]           byte_off;
      logic [reg_idx_w-1:0] rd;
   } lsu_pend_t;

   // Load result for the register file
   typedef struct packed {
      logic [reg_idx_w-1:0] rd;
      logic [xlen-1:0]      data;
   } lsu_wb_t;

   // AHB address phase
   typedef struct packed {
      logic [xlen-1:0] haddr;
      logic [1:0]      htrans;
      logic            hwrite;
      logic [2:0]      hsize;
   } ahb_req_t;

endpackage

`default_nettype wire
